//--- bench/rv_core_checker.sv
module rv_core_checker import rv_pkg::*; (
    input logic  clk_i,
    input logic  reset_i,
    input logic  wb_cyc_i,
    input logic  wb_stb_i,
    input logic  wb_we_i,
    input word_t wb_adr_i,
    input word_t wb_wdat_i,
    input logic  wb_ack_i,
    input logic  commit_i
);

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_i |-> wb_cyc_i)
        else $error("Wishbone stb high without cyc");

    // A stalled request must not change under the slave
    req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_stb_i && !wb_ack_i) |=> ($stable(wb_adr_i) && $stable(wb_we_i) && $stable(wb_wdat_i)))
        else $error("Wishbone request changed before ack");

    adr_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_stb_i |-> (wb_adr_i[1:0] == 2'b00))
        else $error("Wishbone address not word aligned");

    commit_single: assert property (@(posedge clk_i) disable iff (reset_i)
        commit_i |=> !commit_i)
        else $error("Commit strobe high on two cycles in a row");

endmodule

bind rv_core_top rv_core_checker rv_core_checker_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wb_cyc_i  (wb_cyc_o),
    .wb_stb_i  (wb_stb_o),
    .wb_we_i   (wb_we_o),
    .wb_adr_i  (wb_adr_o),
    .wb_wdat_i (wb_dat_o),
    .wb_ack_i  (wb_ack_i),
    .commit_i  (commit)
);

//--- bench/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

    localparam int    NUM_TESTS      = 6;
    localparam int    TIMEOUT_CYCLES = NUM_TESTS * 40 * 12;
    localparam int    MEM_WORDS      = 256;
    localparam word_t DONE_ADDR      = 32'h0000_03FC;  // Store here ends a program
    localparam word_t FILL           = 32'hBAD0_0000;

    logic  clk_i;
    logic  reset_i;
    word_t wb_dat_i;
    logic  wb_ack_i;
    logic  wb_cyc_o;
    logic  wb_stb_o;
    logic  wb_we_o;
    word_t wb_adr_o;
    word_t wb_dat_o;

    word_t       mem [0:MEM_WORDS-1];
    word_t       prog[$];
    word_t       st_addr[$];   // Stores seen on the bus
    word_t       st_data[$];
    word_t       exp_addr[$];
    word_t       exp_data[$];
    logic        done;
    logic        random_ack;
    logic [15:0] lfsr_q;
    int          errors;
    int          failed_tests;
    int          cycle_cnt;

    rv_core_top rv_core_top_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // RV32I encoders
    function automatic word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic word_t lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t rtype(input int f3, input int alt, input int rd,
                                    input int rs1, input int rs2);
        return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input int f3, input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t jalr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
    endfunction

    // Only executes if a jump or branch lands in the wrong place
    function automatic word_t skip_marker();
        return sw(31, 31, 'hF0);
    endfunction

    function automatic word_t pc_now();
        return word_t'(prog.size() * 4);
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic pick_delay(output int delay);
        delay = 0;
        for (int n = 0; n < 2; n++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            delay = delay * 2 + (lfsr_q[0] ? 1 : 0);
        end
    endtask

    // Wishbone slave memory, ack in the request cycle plus the chosen wait
    initial begin
        logic busy;
        int   wait_left;
        logic ack_d;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        lfsr_q    = 16'd72;
        busy      = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk_i);
            #1;
            ack_d = 1'b0;
            if (wb_ack_i || !(wb_cyc_o && wb_stb_o)) begin
                busy = 1'b0;  // Previous transfer taken at this edge
            end
            if (wb_cyc_o && wb_stb_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = 0;
                    if (wb_adr_o[1:0] != 2'b00) begin
                        $display("Bus address %08h is not word aligned", wb_adr_o);
                        errors++;
                    end
                    if (random_ack) begin
                        pick_delay(wait_left);
                    end
                end
                if (wait_left == 0) begin
                    ack_d = 1'b1;
                    if (wb_we_o) begin
                        mem[wb_adr_o[9:2]] = wb_dat_o;
                        if (wb_adr_o == DONE_ADDR) begin
                            done = 1'b1;
                        end else begin
                            st_addr.push_back(wb_adr_o);
                            st_data.push_back(wb_dat_o);
                        end
                    end else begin
                        wb_dat_i = mem[wb_adr_o[9:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
            wb_ack_i = ack_d;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: programs did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %08h, expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic finish_program();
        prog.push_back(sw(0, 0, int'(DONE_ADDR)));
        prog.push_back(jal(0, 0));  // Spin until the next reset
    endtask

    task automatic check_stores();
        if (st_addr.size() != exp_addr.size()) begin
            $display("Store count wrong: saw %0d stores, expected %0d",
                     st_addr.size(), exp_addr.size());
            errors++;
        end else begin
            for (int i = 0; i < st_addr.size(); i++) begin
                check_addr("wb_adr_o", st_addr[i], exp_addr[i]);
                check_word("wb_dat_o", st_data[i], exp_data[i]);
            end
        end
    endtask

    task automatic run_program(input string name);
        int errors_before;
        errors_before = errors;
        @(posedge clk_i);
        #1 reset_i = 1'b1;
        @(posedge clk_i);
        #1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = FILL ^ word_t'(i * 4);
        end
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
        st_addr.delete();
        st_data.delete();
        done = 1'b0;
        repeat (2) @(posedge clk_i);
        #1 reset_i = 1'b0;
        while (!done) begin
            @(posedge clk_i);
        end
        check_stores();
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, errors - errors_before);
            failed_tests++;
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic alu_test();
        word_t a;
        word_t b;
        word_t res [10];
        a = 32'd5;
        b = 32'd0 - 32'd3;
        prog.push_back(addi(31, 0, 'h200));
        prog.push_back(addi(1, 0, 5));
        prog.push_back(addi(2, 0, -3));
        prog.push_back(lui(3, 'h12345));
        prog.push_back(rtype(0, 0, 4, 1, 2));   // ADD
        prog.push_back(rtype(0, 1, 5, 1, 2));   // SUB
        prog.push_back(rtype(7, 0, 6, 1, 2));   // AND
        prog.push_back(rtype(6, 0, 7, 1, 2));   // OR
        prog.push_back(rtype(4, 0, 8, 1, 2));   // XOR
        prog.push_back(rtype(2, 0, 9, 2, 1));   // SLT -3 < 5
        prog.push_back(rtype(2, 0, 10, 1, 2));  // SLT 5 < -3
        for (int r = 1; r <= 10; r++) begin
            prog.push_back(sw(r, 31, (r - 1) * 4));
        end
        finish_program();
        res[0] = a;
        res[1] = b;
        res[2] = 32'h12345 << 12;
        res[3] = a + b;
        res[4] = a - b;
        res[5] = a & b;
        res[6] = a | b;
        res[7] = a ^ b;
        res[8] = 32'd1;  // Signed compare, negative is less
        res[9] = 32'd0;
        for (int i = 0; i < 10; i++) begin
            expect_store(32'h200 + word_t'(i * 4), res[i]);
        end
        run_program("alu_ops");
    endtask

    task automatic load_store_test();
        word_t value;
        value = (32'hCAFE0 << 12) + 32'h123;
        prog.push_back(addi(31, 0, 'h200));
        prog.push_back(lui(1, 'hCAFE0));
        prog.push_back(addi(1, 1, 'h123));
        prog.push_back(sw(1, 31, 'h10));
        prog.push_back(lw(2, 31, 'h10));
        prog.push_back(sw(2, 31, 'h20));  // Loaded value back out
        finish_program();
        expect_store(32'h210, value);
        expect_store(32'h220, value);
        run_program("load_store");
    endtask

    task automatic branch_test(input string name);
        int limit;
        limit = 5;
        prog.push_back(addi(31, 0, 'h200));
        prog.push_back(addi(1, 0, 0));
        prog.push_back(addi(2, 0, limit));
        prog.push_back(addi(1, 1, 1));      // Loop body
        prog.push_back(branch(1, 1, 2, -4));  // BNE back while below limit
        prog.push_back(sw(1, 31, 0));
        prog.push_back(branch(0, 1, 2, 8));   // BEQ taken
        prog.push_back(skip_marker());
        prog.push_back(branch(1, 1, 1, 8));   // BNE not taken
        prog.push_back(sw(2, 31, 4));
        prog.push_back(branch(0, 1, 0, 8));   // BEQ not taken
        prog.push_back(sw(1, 31, 8));
        prog.push_back(branch(1, 1, 0, 8));   // BNE taken
        prog.push_back(skip_marker());
        finish_program();
        expect_store(32'h200, word_t'(limit));  // Loop exits at the limit
        expect_store(32'h204, word_t'(limit));
        expect_store(32'h208, word_t'(limit));
        run_program(name);
    endtask

    task automatic link_test();
        word_t jal_link;
        word_t jalr_link;
        prog.push_back(addi(31, 0, 'h200));
        jal_link = pc_now() + 32'd4;
        prog.push_back(jal(1, 12));
        prog.push_back(skip_marker());
        prog.push_back(skip_marker());
        prog.push_back(sw(1, 31, 0));
        prog.push_back(addi(6, 0, 39));
        jalr_link = pc_now() + 32'd4;
        prog.push_back(jalr(7, 6, 2));  // 39 + 2 = 41, lands on 40
        prog.push_back(skip_marker());
        prog.push_back(skip_marker());
        prog.push_back(skip_marker());
        prog.push_back(sw(7, 31, 4));
        finish_program();
        expect_store(32'h200, jal_link);
        expect_store(32'h204, jalr_link);
        run_program("links");
    endtask

    task automatic zero_reg_test();
        prog.push_back(addi(31, 0, 'h200));
        prog.push_back(addi(0, 0, 99));
        prog.push_back(rtype(0, 0, 0, 31, 31));
        prog.push_back(lui(0, 1));
        prog.push_back(sw(0, 31, 0));
        prog.push_back(addi(2, 0, 3));
        prog.push_back(rtype(0, 0, 3, 0, 2));  // x0 as a source reads zero
        prog.push_back(sw(3, 31, 4));
        finish_program();
        expect_store(32'h200, 32'd0);
        expect_store(32'h204, 32'd3);
        run_program("zero_reg");
    endtask

    initial begin
        reset_i      = 1'b1;
        random_ack   = 1'b0;
        done         = 1'b0;
        errors       = 0;
        failed_tests = 0;
        alu_test();
        load_store_test();
        branch_test("branches");
        link_test();
        zero_reg_test();
        random_ack = 1'b1;
        branch_test("branches_backpressure");
        $display("Tests run: %0d, failing tests: %0d, errors: %0d",
                 NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/control_unit.sv
rtl/reg_alu.sv
rtl/pc_unit.sv
rtl/bus_sequencer.sv
rtl/rv_core_top.sv
bench/rv_core_checker.sv
bench/rv_core_tb.sv

//--- rtl/bus_sequencer.sv
module bus_sequencer import rv_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  word_t pc_i,
    input  word_t data_addr_i,
    input  word_t store_data_i,
    input  logic  is_load_i,
    input  logic  is_store_i,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i,
    output word_t instr_o,
    output word_t mem_rdata_o,
    output logic  commit_o,
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o
);

    seq_state_t state;
    logic       run_q;    // Low until the first edge out of reset
    logic       mem_op;
    word_t      instr_q;

    assign mem_op = is_load_i | is_store_i;

    assign wb_cyc_o = ((state == FETCH) && run_q) || (state == MEM);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = (state == MEM) && is_store_i;
    assign wb_adr_o = (state == MEM) ? data_addr_i : pc_i;
    assign wb_dat_o = store_data_i;

    assign instr_o     = instr_q;
    assign mem_rdata_o = wb_dat_i;  // Valid in the ack cycle, written at commit

    // Plain instructions retire in EXEC, memory ones on data ack
    assign commit_o = ((state == EXEC) && !mem_op) || ((state == MEM) && wb_ack_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= FETCH;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            case (state)
                FETCH:   if (wb_ack_i) state <= EXEC;
                EXEC:    state <= mem_op ? MEM : FETCH;
                MEM:     if (wb_ack_i) state <= FETCH;
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state == FETCH) && wb_ack_i) begin
            instr_q <= wb_dat_i;  // Held until the next fetch
        end
    end

endmodule

//--- rtl/control_unit.sv
module control_unit import rv_pkg::*; (
    input  word_t     instr_i,
    input  logic      eq_i,
    output logic      reg_write_o,
    output logic      alu_src_o,
    output alu_ctrl_t alu_ctrl_o,
    output logic      result_src_o,
    output logic      link_sel_o,
    output logic      is_load_o,
    output logic      is_store_o,
    output logic      pc_src_o,
    output logic      jalr_sel_o,
    output word_t     imm_op_o
);

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7_5 = instr_i[30];  // Selects SUB over ADD

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        reg_write_o  = 1'b0;  // Defaults give a no-op
        alu_src_o    = 1'b0;
        alu_ctrl_o   = ALU_ADD;
        result_src_o = 1'b0;
        link_sel_o   = 1'b0;
        is_load_o    = 1'b0;
        is_store_o   = 1'b0;
        pc_src_o     = 1'b0;
        jalr_sel_o   = 1'b0;
        imm_op_o     = imm_i;
        case (opcode)
            OP_IMM: begin
                reg_write_o = (funct3 == 3'b000);  // ADDI only
                alu_src_o   = 1'b1;
            end
            OP_REG: begin
                reg_write_o = 1'b1;
                case (funct3)
                    3'b000:  alu_ctrl_o = funct7_5 ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_ctrl_o = ALU_SLT;
                    3'b100:  alu_ctrl_o = ALU_XOR;
                    3'b110:  alu_ctrl_o = ALU_OR;
                    3'b111:  alu_ctrl_o = ALU_AND;
                    default: reg_write_o = 1'b0;  // Shifts not supported
                endcase
            end
            OP_LUI: begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_ctrl_o  = ALU_PASSB;
                imm_op_o    = imm_u;
            end
            OP_LOAD: begin
                reg_write_o  = (funct3 == 3'b010);  // LW only
                is_load_o    = (funct3 == 3'b010);
                alu_src_o    = 1'b1;
                result_src_o = 1'b1;
            end
            OP_STORE: begin
                is_store_o = (funct3 == 3'b010);  // SW only
                alu_src_o  = 1'b1;
                imm_op_o   = imm_s;
            end
            OP_BRANCH: begin
                imm_op_o = imm_b;
                case (funct3)
                    3'b000:  pc_src_o = eq_i;   // BEQ
                    3'b001:  pc_src_o = ~eq_i;  // BNE
                    default: pc_src_o = 1'b0;
                endcase
            end
            OP_JAL: begin
                reg_write_o = 1'b1;
                link_sel_o  = 1'b1;
                pc_src_o    = 1'b1;
                imm_op_o    = imm_j;
            end
            OP_JALR: begin
                reg_write_o = 1'b1;
                link_sel_o  = 1'b1;
                alu_src_o   = 1'b1;
                jalr_sel_o  = 1'b1;  // Target comes from the ALU sum
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/pc_unit.sv
`include "rv_defines.svh"

module pc_unit import rv_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  commit_i,
    input  word_t imm_op_i,
    input  logic  pc_src_i,
    input  logic  jalr_sel_i,
    input  word_t jalr_target_i,
    output word_t pc_o,
    output word_t pc_plus4_o
);

    word_t pc_q;
    word_t pc_target;
    word_t next_pc;

    assign pc_o       = pc_q;
    assign pc_plus4_o = pc_q + 32'd4;
    assign pc_target  = pc_q + imm_op_i;  // Branch and JAL offset

    always_comb begin
        if (jalr_sel_i) begin
            next_pc = {jalr_target_i[31:1], 1'b0};  // JALR drops bit 0
        end else if (pc_src_i) begin
            next_pc = pc_target;
        end else begin
            next_pc = pc_plus4_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (commit_i) begin
            pc_q <= next_pc;  // One update per instruction
        end
    end

endmodule

//--- rtl/reg_alu.sv
`include "rv_defines.svh"

module reg_alu import rv_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      reg_write_i,
    input  logic      commit_i,
    input  logic      result_src_i,
    input  logic      link_sel_i,
    input  logic      alu_src_i,
    input  alu_ctrl_t alu_ctrl_i,
    input  word_t     imm_op_i,
    input  word_t     mem_rdata_i,
    input  word_t     pc_plus4_i,
    output logic      eq_o,
    output word_t     alu_out_o,
    output word_t     rs2_val_o
);

    word_t regs [1:(2**`REG_ADDR_W)-1];  // x0 has no storage
    word_t rs1_val;
    word_t op_b;
    word_t wb_val;

    assign rs1_val   = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_val_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    assign eq_o      = (rs1_val == rs2_val_o);  // Branch compare

    assign op_b = alu_src_i ? imm_op_i : rs2_val_o;

    always_comb begin
        case (alu_ctrl_i)
            ALU_ADD:   alu_out_o = rs1_val + op_b;
            ALU_SUB:   alu_out_o = rs1_val - op_b;
            ALU_AND:   alu_out_o = rs1_val & op_b;
            ALU_OR:    alu_out_o = rs1_val | op_b;
            ALU_XOR:   alu_out_o = rs1_val ^ op_b;
            ALU_SLT:   alu_out_o = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_PASSB: alu_out_o = op_b;
            default:   alu_out_o = '0;
        endcase
    end

    // Link address wins over load data and ALU result
    always_comb begin
        if (link_sel_i) begin
            wb_val = pc_plus4_i;
        end else if (result_src_i) begin
            wb_val = mem_rdata_i;
        end else begin
            wb_val = alu_out_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_i && reg_write_i && (rd_i != '0)) begin
            regs[rd_i] <= wb_val;  // Writes to x0 dropped
        end
    end

endmodule

//--- rtl/rv_core_top.sv
module rv_core_top import rv_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    input  word_t wb_dat_i,
    input  logic  wb_ack_i,
    output logic  wb_cyc_o,
    output logic  wb_stb_o,
    output logic  wb_we_o,
    output word_t wb_adr_o,
    output word_t wb_dat_o
);

    word_t     instr;       // Held instruction
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     pc;
    word_t     pc_plus4;
    word_t     imm_op;
    word_t     alu_out;     // Data address and JALR target
    word_t     rs2_val;     // Store data
    word_t     mem_rdata;
    alu_ctrl_t alu_ctrl;
    logic      commit;
    logic      reg_write;
    logic      alu_src;
    logic      result_src;
    logic      link_sel;
    logic      is_load;
    logic      is_store;
    logic      pc_src;
    logic      jalr_sel;
    logic      eq;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    bus_sequencer bus_sequencer_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .pc_i         (pc),
        .data_addr_i  (alu_out),
        .store_data_i (rs2_val),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .wb_dat_i     (wb_dat_i),
        .wb_ack_i     (wb_ack_i),
        .instr_o      (instr),
        .mem_rdata_o  (mem_rdata),
        .commit_o     (commit),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_we_o      (wb_we_o),
        .wb_adr_o     (wb_adr_o),
        .wb_dat_o     (wb_dat_o)
    );

    control_unit control_unit_i (
        .instr_i      (instr),
        .eq_i         (eq),
        .reg_write_o  (reg_write),
        .alu_src_o    (alu_src),
        .alu_ctrl_o   (alu_ctrl),
        .result_src_o (result_src),
        .link_sel_o   (link_sel),
        .is_load_o    (is_load),
        .is_store_o   (is_store),
        .pc_src_o     (pc_src),
        .jalr_sel_o   (jalr_sel),
        .imm_op_o     (imm_op)
    );

    reg_alu reg_alu_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rd_i         (rd),
        .reg_write_i  (reg_write),
        .commit_i     (commit),
        .result_src_i (result_src),
        .link_sel_i   (link_sel),
        .alu_src_i    (alu_src),
        .alu_ctrl_i   (alu_ctrl),
        .imm_op_i     (imm_op),
        .mem_rdata_i  (mem_rdata),
        .pc_plus4_i   (pc_plus4),
        .eq_o         (eq),
        .alu_out_o    (alu_out),
        .rs2_val_o    (rs2_val)
    );

    pc_unit pc_unit_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .commit_i      (commit),
        .imm_op_i      (imm_op),
        .pc_src_i      (pc_src),
        .jalr_sel_i    (jalr_sel),
        .jalr_target_i (alu_out),
        .pc_o          (pc),
        .pc_plus4_o    (pc_plus4)
    );

endmodule

//--- rtl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- rtl/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    // Data, address, PC and immediate values
    typedef logic [`XLEN-1:0] word_t;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // ALU operation select
    typedef logic [3:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_ADD   = 4'd0;
    localparam alu_ctrl_t ALU_SUB   = 4'd1;
    localparam alu_ctrl_t ALU_AND   = 4'd2;
    localparam alu_ctrl_t ALU_OR    = 4'd3;
    localparam alu_ctrl_t ALU_XOR   = 4'd4;
    localparam alu_ctrl_t ALU_SLT   = 4'd5;  // Signed compare
    localparam alu_ctrl_t ALU_PASSB = 4'd6;  // Operand B straight through, for LUI

    // Bus sequencer phases, one instruction in flight
    typedef enum logic [1:0] {
        FETCH,  // Instruction read on the bus
        EXEC,   // Decode and execute, commit if no memory access
        MEM     // Data read or write on the bus
    } seq_state_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module rv_core_tb -o rv_core_sim
./obj_dir/rv_core_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"
